// ==== src/frame_pkg.sv ====
// frame geometry and SRAM memory map
// one luminance plane of pre-IDCT samples in, packed pixels out
package frame_pkg;

	// SRAM word address and data
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_data_t;

	// frame size in 8x8 blocks
	localparam int BLOCK_COLS = 4;
	localparam int BLOCK_ROWS = 2;

	// one sample per word, two pixels per word
	localparam sram_addr_t SAMPLE_ROW_WORDS = sram_addr_t'(BLOCK_COLS * 8);
	localparam sram_addr_t PIXEL_ROW_WORDS = sram_addr_t'(BLOCK_COLS * 4);

	// region bases
	localparam sram_addr_t PRE_IDCT_BASE = 18'd1024;
	localparam sram_addr_t PIXEL_BASE = 18'd0;

	// data returns this many cycles after the address
	localparam int READ_LATENCY = 2;

endpackage

// ==== src/idct_pkg.sv ====
// IDCT datapath types and constants
// sample, accumulator and pixel types, pass shifts and the
// fixed point cosine table, scaled by 4096
package idct_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic signed [31:0] acc_t;
	typedef logic [7:0] pixel_t;
	typedef logic signed [15:0] coeff_t;

	// row * 8 + column
	typedef logic [5:0] buf_addr_t;

	// T = S' * C keeps sum >> 8, S = C^T * T keeps sum >> 16
	localparam int PASS1_SHIFT = 8;
	localparam int PASS2_SHIFT = 16;

	// C[k][n], k is the frequency index
	localparam coeff_t DCT_COEFF [8][8] = '{
		'{ 1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448},
		'{ 2009,  1703,  1138,   400,  -400, -1138, -1703, -2009},
		'{ 1892,   784,  -784, -1892, -1892,  -784,   784,  1892},
		'{ 1703,  -400, -2009, -1138,  1138,  2009,   400, -1703},
		'{ 1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448},
		'{ 1138, -2009,   400,  1703, -1703,  -400,  2009, -1138},
		'{  784, -1892,  1892,  -784,  -784,  1892, -1892,   784},
		'{  400, -1138,  1703, -2009,  2009, -1703,  1138,  -400}
	};

endpackage

// ==== src/block_buffer.sv ====
// 8x8 block memory
// one write port, one read port, read data registered
// the element type is set per instance
module block_buffer #(
	parameter type elem_t = logic [15:0]
) (
	input  logic                Clock,
	input  logic                wr_en_i,
	input  idct_pkg::buf_addr_t wr_addr_i,
	input  elem_t               wr_data_i,
	input  idct_pkg::buf_addr_t rd_addr_i,
	output elem_t               rd_data_o
);

elem_t mem [64];

always_ff @(posedge Clock) begin
	if (wr_en_i) begin
		mem[wr_addr_i] <= wr_data_i;
	end
end

// one cycle read
always_ff @(posedge Clock) begin
	rd_data_o <= mem[rd_addr_i];
end

endmodule

// ==== src/block_fetch.sv ====
// block fetch
// reads the 64 samples of one block from SRAM, one word per cycle,
// and lands each returning word in its sample buffer slot
module block_fetch (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  go_i,
	input  frame_pkg::sram_addr_t base_i,
	input  frame_pkg::sram_data_t sram_read_data_i,
	output frame_pkg::sram_addr_t sram_address_o,
	output logic                  buf_wr_en_o,
	output idct_pkg::buf_addr_t   buf_wr_addr_o,
	output idct_pkg::sample_t     buf_wr_data_o,
	output logic                  done_o
);

localparam int LAT = frame_pkg::READ_LATENCY;

logic busy;
logic issue;
logic [2:0] row;
logic [2:0] col;
logic [5:0] next_pos;
frame_pkg::sram_addr_t next_addr;
logic [LAT-1:0] lat_valid;
idct_pkg::buf_addr_t lat_idx [LAT];

assign next_pos = {row, col} + 6'd1;
assign next_addr = base_i + frame_pkg::sram_addr_t'(next_pos[5:3]) * frame_pkg::SAMPLE_ROW_WORDS
	+ frame_pkg::sram_addr_t'(next_pos[2:0]);

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		busy <= 1'b0;
		issue <= 1'b0;
		row <= '0;
		col <= '0;
		sram_address_o <= '0;
		lat_valid <= '0;
		buf_wr_en_o <= 1'b0;
		buf_wr_addr_o <= '0;
		done_o <= 1'b0;
	end else begin
		lat_valid <= {lat_valid[LAT-2:0], issue};
		buf_wr_en_o <= lat_valid[LAT-1];
		buf_wr_addr_o <= lat_idx[LAT-1];
		done_o <= lat_valid[LAT-1] && (lat_idx[LAT-1] == 6'd63);
		if (lat_valid[LAT-1] && (lat_idx[LAT-1] == 6'd63)) begin
			busy <= 1'b0;
		end
		if (go_i && !busy) begin
			busy <= 1'b1;
			issue <= 1'b1;
			row <= '0;
			col <= '0;
			sram_address_o <= base_i;
		end else if (issue) begin
			if ({row, col} == 6'd63) begin
				issue <= 1'b0;
			end else begin
				row <= next_pos[5:3];
				col <= next_pos[2:0];
				sram_address_o <= next_addr;
			end
		end
	end
end

// buffer index follows its address through the read latency
always_ff @(posedge Clock) begin
	lat_idx[0] <= {row, col};
	for (int i = 1; i < LAT; i++) begin
		lat_idx[i] <= lat_idx[i-1];
	end
	buf_wr_data_o <= idct_pkg::sample_t'(sram_read_data_i);
end

endmodule

// ==== src/matrix_engine.sv ====
// 8x8 matrix multiply engine for both IDCT passes
// pass 0: T = S' * C, one sample row per output row, sum >> 8
// pass 1: S = C^T * T, one T column per output column, sum >> 16, clip
// two products per cycle, four cycles per output element
module matrix_engine (
	input  logic                Clock,
	input  logic                Resetn,
	input  logic                go_i,
	input  logic                pass_i,
	input  idct_pkg::sample_t   sample_rd_data_i,
	input  idct_pkg::acc_t      t_rd_data_i,
	output idct_pkg::buf_addr_t rd_addr_o,
	output logic                t_wr_en_o,
	output idct_pkg::acc_t      t_wr_data_o,
	output logic                pix_wr_en_o,
	output idct_pkg::pixel_t    pix_wr_data_o,
	output idct_pkg::buf_addr_t wr_addr_o,
	output logic                done_o
);

typedef enum logic [1:0] {ENG_IDLE, ENG_LOAD, ENG_CALC} eng_state_t;

eng_state_t state;
logic pass_q;
logic [2:0] outer;
logic [2:0] inner;
logic [1:0] beat;
logic start_fetch;
logic [2:0] fetch_line_next;
logic fetch_on;
logic [2:0] fetch_k;
logic [2:0] fetch_line;
logic [1:0] cap_valid;
logic [2:0] cap_k [2];
logic line_loaded;
logic row_switch;
idct_pkg::acc_t cur_row [8];
idct_pkg::acc_t nxt_row [8];
idct_pkg::acc_t operand;
idct_pkg::acc_t acc;
idct_pkg::acc_t prod0;
idct_pkg::acc_t prod1;
idct_pkg::acc_t sum;
idct_pkg::acc_t t_val;
idct_pkg::acc_t p_val;

assign operand = pass_q ? t_rd_data_i : idct_pkg::acc_t'(sample_rd_data_i);

// next line streams in over the last three columns of the current one
assign start_fetch = ((state == ENG_IDLE) && go_i) ||
	((state == ENG_CALC) && (inner == 3'd5) && (beat == 2'd0) && (outer != 3'd7));
assign fetch_line_next = (state == ENG_IDLE) ? 3'd0 : outer + 3'd1;
assign row_switch = (state == ENG_CALC) && (beat == 2'd3) && (inner == 3'd7);

always_comb begin
	prod0 = cur_row[{beat, 1'b0}] * idct_pkg::acc_t'(idct_pkg::DCT_COEFF[{beat, 1'b0}][inner]);
	prod1 = cur_row[{beat, 1'b1}] * idct_pkg::acc_t'(idct_pkg::DCT_COEFF[{beat, 1'b1}][inner]);
	sum = prod0 + prod1;
	if (beat != 2'd0) begin
		sum = sum + acc;
	end
	t_val = sum >>> idct_pkg::PASS1_SHIFT;
	p_val = sum >>> idct_pkg::PASS2_SHIFT;
end

// operand reads, two cycles from issue to capture
always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		fetch_on <= 1'b0;
		fetch_k <= '0;
		fetch_line <= '0;
		cap_valid <= '0;
		line_loaded <= 1'b0;
		rd_addr_o <= '0;
	end else begin
		cap_valid <= {cap_valid[0], fetch_on};
		line_loaded <= cap_valid[1] && (cap_k[1] == 3'd7);
		if (fetch_on) begin
			rd_addr_o <= pass_q ? {fetch_k, fetch_line} : {fetch_line, fetch_k};
			fetch_k <= fetch_k + 3'd1;
			if (fetch_k == 3'd7) begin
				fetch_on <= 1'b0;
			end
		end
		if (start_fetch) begin
			fetch_on <= 1'b1;
			fetch_k <= '0;
			fetch_line <= fetch_line_next;
		end
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= ENG_IDLE;
		pass_q <= 1'b0;
		outer <= '0;
		inner <= '0;
		beat <= '0;
		t_wr_en_o <= 1'b0;
		pix_wr_en_o <= 1'b0;
		wr_addr_o <= '0;
		done_o <= 1'b0;
	end else begin
		t_wr_en_o <= 1'b0;
		pix_wr_en_o <= 1'b0;
		done_o <= 1'b0;
		case (state)
			ENG_IDLE: begin
				if (go_i) begin
					pass_q <= pass_i;
					outer <= '0;
					inner <= '0;
					beat <= '0;
					state <= ENG_LOAD;
				end
			end
			ENG_LOAD: begin
				if (line_loaded) begin
					state <= ENG_CALC;
				end
			end
			ENG_CALC: begin
				beat <= beat + 2'd1;
				if (beat == 2'd3) begin
					t_wr_en_o <= !pass_q;
					pix_wr_en_o <= pass_q;
					wr_addr_o <= pass_q ? {inner, outer} : {outer, inner};
					inner <= inner + 3'd1;
					if (inner == 3'd7) begin
						outer <= outer + 3'd1;
						if (outer == 3'd7) begin
							done_o <= 1'b1;
							state <= ENG_IDLE;
						end
					end
				end
			end
			default: state <= ENG_IDLE;
		endcase
	end
end

always_ff @(posedge Clock) begin
	cap_k[0] <= fetch_k;
	cap_k[1] <= cap_k[0];
	if (cap_valid[1]) begin
		nxt_row[cap_k[1]] <= operand;
	end
	if (((state == ENG_LOAD) && line_loaded) || row_switch) begin
		cur_row <= nxt_row;
	end
	if (state == ENG_CALC) begin
		acc <= sum;
	end
	if ((state == ENG_CALC) && (beat == 2'd3)) begin
		t_wr_data_o <= t_val;
		if (p_val < 0) begin
			pix_wr_data_o <= 8'd0;
		end else if (p_val > 255) begin
			pix_wr_data_o <= 8'd255;
		end else begin
			pix_wr_data_o <= p_val[7:0];
		end
	end
end

endmodule

// ==== src/block_writeback.sv ====
// block writeback
// reads the pixel buffer in order and writes one word per pixel
// pair to SRAM, even column in the high byte
module block_writeback (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  go_i,
	input  frame_pkg::sram_addr_t base_i,
	input  idct_pkg::pixel_t      pix_rd_data_i,
	output idct_pkg::buf_addr_t   pix_rd_addr_o,
	output frame_pkg::sram_addr_t sram_address_o,
	output frame_pkg::sram_data_t sram_write_data_o,
	output logic                  sram_we_n_o,
	output logic                  done_o
);

logic busy;
logic rd_on;
logic d_valid;
idct_pkg::buf_addr_t d_idx;
logic last_wr;
idct_pkg::pixel_t even_q;
frame_pkg::sram_addr_t pair_addr;

// row * PIXEL_ROW_WORDS + column / 2
assign pair_addr = base_i + frame_pkg::sram_addr_t'(d_idx[5:3]) * frame_pkg::PIXEL_ROW_WORDS
	+ frame_pkg::sram_addr_t'(d_idx[2:1]);

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		busy <= 1'b0;
		rd_on <= 1'b0;
		pix_rd_addr_o <= '0;
		d_valid <= 1'b0;
		d_idx <= '0;
		last_wr <= 1'b0;
		sram_address_o <= '0;
		sram_we_n_o <= 1'b1;
		done_o <= 1'b0;
	end else begin
		d_valid <= rd_on;
		d_idx <= pix_rd_addr_o;
		sram_we_n_o <= 1'b1;
		last_wr <= 1'b0;
		done_o <= last_wr;
		if (last_wr) begin
			busy <= 1'b0;
		end
		if (go_i && !busy) begin
			busy <= 1'b1;
			rd_on <= 1'b1;
			pix_rd_addr_o <= '0;
		end else if (rd_on) begin
			if (pix_rd_addr_o == 6'd63) begin
				rd_on <= 1'b0;
			end else begin
				pix_rd_addr_o <= pix_rd_addr_o + 6'd1;
			end
		end
		// odd pixel completes the pair
		if (d_valid && d_idx[0]) begin
			sram_we_n_o <= 1'b0;
			sram_address_o <= pair_addr;
			last_wr <= (d_idx == 6'd63);
		end
	end
end

always_ff @(posedge Clock) begin
	if (d_valid && !d_idx[0]) begin
		even_q <= pix_rd_data_i;
	end
	if (d_valid && d_idx[0]) begin
		sram_write_data_o <= {even_q, pix_rd_data_i};
	end
end

endmodule

// ==== src/idct_sequencer.sv ====
// IDCT block sequencer
// walks the frame block by block in row-major order, runs fetch,
// both IDCT passes and writeback for each block, and owns the SRAM port
module idct_sequencer (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  start_i,
	input  logic                  fetch_done_i,
	input  logic                  engine_done_i,
	input  logic                  wb_done_i,
	input  frame_pkg::sram_addr_t fetch_address_i,
	input  frame_pkg::sram_addr_t wb_address_i,
	input  frame_pkg::sram_data_t wb_write_data_i,
	input  logic                  wb_we_n_i,
	output logic                  fetch_go_o,
	output logic                  engine_go_o,
	output logic                  engine_pass_o,
	output logic                  wb_go_o,
	output frame_pkg::sram_addr_t fetch_base_o,
	output frame_pkg::sram_addr_t wb_base_o,
	output frame_pkg::sram_addr_t sram_address_o,
	output frame_pkg::sram_data_t sram_write_data_o,
	output logic                  sram_we_n_o,
	output logic                  done_o
);

localparam int COL_W = $clog2(frame_pkg::BLOCK_COLS);
localparam int ROW_W = $clog2(frame_pkg::BLOCK_ROWS);

typedef enum logic [2:0] {SEQ_IDLE, SEQ_FETCH, SEQ_PASS0, SEQ_PASS1, SEQ_WB} seq_state_t;

seq_state_t state;
logic [COL_W-1:0] bcol;
logic [ROW_W-1:0] brow;
logic last_block;
logic sel_fetch;
logic sel_wb;
frame_pkg::sram_addr_t held_addr;

assign last_block = (bcol == COL_W'(frame_pkg::BLOCK_COLS - 1)) &&
	(brow == ROW_W'(frame_pkg::BLOCK_ROWS - 1));

// a block is 8 sample words or 4 pixel words wide
assign fetch_base_o = frame_pkg::PRE_IDCT_BASE
	+ frame_pkg::sram_addr_t'(brow) * (frame_pkg::SAMPLE_ROW_WORDS << 3)
	+ frame_pkg::sram_addr_t'({bcol, 3'b000});
assign wb_base_o = frame_pkg::PIXEL_BASE
	+ frame_pkg::sram_addr_t'(brow) * (frame_pkg::PIXEL_ROW_WORDS << 3)
	+ frame_pkg::sram_addr_t'({bcol, 2'b00});

assign sel_fetch = (state == SEQ_FETCH);
assign sel_wb = (state == SEQ_WB);

always_comb begin
	sram_address_o = held_addr;
	sram_write_data_o = '0;
	sram_we_n_o = 1'b1;
	if (sel_fetch) begin
		sram_address_o = fetch_address_i;
	end
	if (sel_wb) begin
		sram_address_o = wb_address_i;
		sram_write_data_o = wb_write_data_i;
		sram_we_n_o = wb_we_n_i;
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= SEQ_IDLE;
		bcol <= '0;
		brow <= '0;
		fetch_go_o <= 1'b0;
		engine_go_o <= 1'b0;
		engine_pass_o <= 1'b0;
		wb_go_o <= 1'b0;
		done_o <= 1'b0;
		held_addr <= '0;
	end else begin
		fetch_go_o <= 1'b0;
		engine_go_o <= 1'b0;
		wb_go_o <= 1'b0;
		done_o <= 1'b0;
		held_addr <= sram_address_o;
		case (state)
			SEQ_IDLE: begin
				if (start_i) begin
					bcol <= '0;
					brow <= '0;
					fetch_go_o <= 1'b1;
					state <= SEQ_FETCH;
				end
			end
			SEQ_FETCH: begin
				if (fetch_done_i) begin
					engine_pass_o <= 1'b0;
					engine_go_o <= 1'b1;
					state <= SEQ_PASS0;
				end
			end
			SEQ_PASS0: begin
				if (engine_done_i) begin
					engine_pass_o <= 1'b1;
					engine_go_o <= 1'b1;
					state <= SEQ_PASS1;
				end
			end
			SEQ_PASS1: begin
				if (engine_done_i) begin
					wb_go_o <= 1'b1;
					state <= SEQ_WB;
				end
			end
			SEQ_WB: begin
				if (wb_done_i) begin
					if (last_block) begin
						done_o <= 1'b1;
						state <= SEQ_IDLE;
					end else begin
						// next block, wrapping to the next block row
						if (bcol == COL_W'(frame_pkg::BLOCK_COLS - 1)) begin
							bcol <= '0;
							brow <= brow + ROW_W'(1);
						end else begin
							bcol <= bcol + COL_W'(1);
						end
						fetch_go_o <= 1'b1;
						state <= SEQ_FETCH;
					end
				end
			end
			default: state <= SEQ_IDLE;
		endcase
	end
end

endmodule

// ==== src/idct_top.sv ====
// block IDCT decoder top level
// sequencer, fetch, matrix engine and writeback around three block
// buffers holding samples, the intermediate T matrix and pixels
module idct_top (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  start_i,
	input  frame_pkg::sram_data_t sram_read_data_i,
	output frame_pkg::sram_addr_t sram_address_o,
	output frame_pkg::sram_data_t sram_write_data_o,
	output logic                  sram_we_n_o,
	output logic                  done_o
);

logic fetch_go;
logic fetch_done;
logic engine_go;
logic engine_pass;
logic engine_done;
logic wb_go;
logic wb_done;
frame_pkg::sram_addr_t fetch_base;
frame_pkg::sram_addr_t wb_base;
frame_pkg::sram_addr_t fetch_address;
frame_pkg::sram_addr_t wb_address;
frame_pkg::sram_data_t wb_write_data;
logic wb_we_n;

logic sample_wr_en;
idct_pkg::buf_addr_t sample_wr_addr;
idct_pkg::sample_t sample_wr_data;
idct_pkg::sample_t sample_rd_data;
idct_pkg::buf_addr_t engine_rd_addr;
idct_pkg::buf_addr_t engine_wr_addr;
logic t_wr_en;
idct_pkg::acc_t t_wr_data;
idct_pkg::acc_t t_rd_data;
logic pix_wr_en;
idct_pkg::pixel_t pix_wr_data;
idct_pkg::pixel_t pix_rd_data;
idct_pkg::buf_addr_t pix_rd_addr;

idct_sequencer i_idct_sequencer (
	.Clock(Clock), .Resetn(Resetn), .start_i(start_i),
	.fetch_done_i(fetch_done), .engine_done_i(engine_done), .wb_done_i(wb_done),
	.fetch_address_i(fetch_address), .wb_address_i(wb_address),
	.wb_write_data_i(wb_write_data), .wb_we_n_i(wb_we_n),
	.fetch_go_o(fetch_go), .engine_go_o(engine_go), .engine_pass_o(engine_pass),
	.wb_go_o(wb_go), .fetch_base_o(fetch_base), .wb_base_o(wb_base),
	.sram_address_o(sram_address_o), .sram_write_data_o(sram_write_data_o),
	.sram_we_n_o(sram_we_n_o), .done_o(done_o)
);

block_fetch i_block_fetch (
	.Clock(Clock), .Resetn(Resetn), .go_i(fetch_go), .base_i(fetch_base),
	.sram_read_data_i(sram_read_data_i), .sram_address_o(fetch_address),
	.buf_wr_en_o(sample_wr_en), .buf_wr_addr_o(sample_wr_addr),
	.buf_wr_data_o(sample_wr_data), .done_o(fetch_done)
);

matrix_engine i_matrix_engine (
	.Clock(Clock), .Resetn(Resetn), .go_i(engine_go), .pass_i(engine_pass),
	.sample_rd_data_i(sample_rd_data), .t_rd_data_i(t_rd_data), .rd_addr_o(engine_rd_addr),
	.t_wr_en_o(t_wr_en), .t_wr_data_o(t_wr_data), .pix_wr_en_o(pix_wr_en),
	.pix_wr_data_o(pix_wr_data), .wr_addr_o(engine_wr_addr), .done_o(engine_done)
);

block_writeback i_block_writeback (
	.Clock(Clock), .Resetn(Resetn), .go_i(wb_go), .base_i(wb_base),
	.pix_rd_data_i(pix_rd_data), .pix_rd_addr_o(pix_rd_addr), .sram_address_o(wb_address),
	.sram_write_data_o(wb_write_data), .sram_we_n_o(wb_we_n), .done_o(wb_done)
);

block_buffer #(.elem_t(idct_pkg::sample_t)) i_sample_buffer (
	.Clock(Clock), .wr_en_i(sample_wr_en), .wr_addr_i(sample_wr_addr),
	.wr_data_i(sample_wr_data), .rd_addr_i(engine_rd_addr), .rd_data_o(sample_rd_data)
);

block_buffer #(.elem_t(idct_pkg::acc_t)) i_t_buffer (
	.Clock(Clock), .wr_en_i(t_wr_en), .wr_addr_i(engine_wr_addr),
	.wr_data_i(t_wr_data), .rd_addr_i(engine_rd_addr), .rd_data_o(t_rd_data)
);

block_buffer #(.elem_t(idct_pkg::pixel_t)) i_pixel_buffer (
	.Clock(Clock), .wr_en_i(pix_wr_en), .wr_addr_i(engine_wr_addr),
	.wr_data_i(pix_wr_data), .rd_addr_i(pix_rd_addr), .rd_data_o(pix_rd_data)
);

endmodule

// ==== verification/idct_chk.sv ====
// SRAM port checks on the IDCT sequencer
// writes stay in the pixel region, done is a single pulse,
// fetch and writeback act only while they own the port
module idct_chk (
	input logic                  Clock,
	input logic                  Resetn,
	input frame_pkg::sram_addr_t sram_address_o,
	input logic                  sram_we_n_o,
	input logic                  done_o,
	input logic                  fetch_done_i,
	input logic                  wb_we_n_i,
	input logic                  sel_fetch,
	input logic                  sel_wb
);

localparam frame_pkg::sram_addr_t PIXEL_END = frame_pkg::PIXEL_BASE
	+ frame_pkg::PIXEL_ROW_WORDS * frame_pkg::sram_addr_t'(frame_pkg::BLOCK_ROWS * 8);

write_in_pixels: assert property (@(posedge Clock) disable iff (!Resetn)
	!sram_we_n_o |-> (sram_address_o >= frame_pkg::PIXEL_BASE) && (sram_address_o < PIXEL_END))
	else $error("SRAM write outside the pixel region");

done_one_cycle: assert property (@(posedge Clock) disable iff (!Resetn)
	done_o |=> !done_o)
	else $error("done_o high for more than one cycle");

// writeback only writes while the port is routed to it
single_owner: assert property (@(posedge Clock) disable iff (!Resetn)
	!wb_we_n_i |-> sel_wb)
	else $error("writeback writes while it does not own the SRAM port");

fetch_owner: assert property (@(posedge Clock) disable iff (!Resetn)
	fetch_done_i |-> sel_fetch)
	else $error("fetch completes while it does not own the SRAM port");

endmodule

bind idct_sequencer idct_chk i_idct_chk (
	.Clock(Clock), .Resetn(Resetn), .sram_address_o(sram_address_o),
	.sram_we_n_o(sram_we_n_o), .done_o(done_o), .fetch_done_i(fetch_done_i),
	.wb_we_n_i(wb_we_n_i), .sel_fetch(sel_fetch), .sel_wb(sel_wb)
);

// ==== verification/idct_tb.sv ====
// testbench for the block IDCT decoder
// behavioral SRAM with two-cycle reads, a reference IDCT model
// and directed tests over whole frames
module idct_tb;

localparam int MEM_WORDS = 2048;
localparam int TIMEOUT = 40000;
localparam int FRAME_ROWS = frame_pkg::BLOCK_ROWS * 8;
localparam int FRAME_COLS = frame_pkg::BLOCK_COLS * 8;

logic Clock;
logic Resetn;
logic start_i;
frame_pkg::sram_data_t sram_read_data_i = '0;
frame_pkg::sram_addr_t sram_address_o;
frame_pkg::sram_data_t sram_write_data_o;
logic sram_we_n_o;
logic done_o;

frame_pkg::sram_data_t mem [MEM_WORDS];
frame_pkg::sram_data_t expect_mem [MEM_WORDS];
frame_pkg::sram_data_t rd_stage;
int samples [FRAME_ROWS][FRAME_COLS];
int seed;

idct_top i_idct_top (
	.Clock(Clock), .Resetn(Resetn), .start_i(start_i),
	.sram_read_data_i(sram_read_data_i), .sram_address_o(sram_address_o),
	.sram_write_data_o(sram_write_data_o), .sram_we_n_o(sram_we_n_o), .done_o(done_o)
);

initial begin
	Clock = 1'b0;
	forever #20 Clock = ~Clock;
end

// SRAM with two-cycle read latency
always @(posedge Clock) begin
	rd_stage <= mem[sram_address_o[10:0]];
	sram_read_data_i <= rd_stage;
	if (!sram_we_n_o) begin
		mem[sram_address_o[10:0]] <= sram_write_data_o;
	end
end

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Simulation FAILED");
	$fatal(1);
endtask

task automatic compare_word(input string name, input frame_pkg::sram_data_t exp_v,
	input frame_pkg::sram_data_t act_v);
	if (exp_v !== act_v) begin
		$display("Error %s: expected %h, actual %h", name, exp_v, act_v);
		fail_run("word mismatch");
	end
endtask

task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
	if (exp_v !== act_v) begin
		$display("Error %s: expected %b, actual %b", name, exp_v, act_v);
		fail_run("flag mismatch");
	end
endtask

// samples: 0 zero, 1 DC per block, 2 random, 3 large DC of alternating sign
task automatic load_frame(input int mode);
	int v;
	for (int a = 0; a < MEM_WORDS; a++) begin
		mem[a] = frame_pkg::sram_data_t'(a * 37) ^ 16'h5A3C;
	end
	for (int r = 0; r < FRAME_ROWS; r++) begin
		for (int c = 0; c < FRAME_COLS; c++) begin
			v = 0;
			if (mode == 1 && r % 8 == 0 && c % 8 == 0) begin
				v = ((r / 8) * frame_pkg::BLOCK_COLS + c / 8) * 130 + 100;
			end else if (mode == 2) begin
				v = ($random(seed) & 511) - 256;
			end else if (mode == 3 && r % 8 == 0 && c % 8 == 0) begin
				v = (((r / 8 + c / 8) % 2) == 0) ? 2090 : -2090;
			end
			samples[r][c] = v;
			mem[frame_pkg::PRE_IDCT_BASE + r * FRAME_COLS + c] = frame_pkg::sram_data_t'(v);
		end
	end
	expect_mem = mem;
endtask

// T = S' * C >> 8, then S = C^T * T >> 16 clipped, per block
task automatic build_expected();
	longint t [8][8];
	longint sum;
	int pix [8];
	int addr;
	for (int br = 0; br < frame_pkg::BLOCK_ROWS; br++) begin
		for (int bc = 0; bc < frame_pkg::BLOCK_COLS; bc++) begin
			for (int r = 0; r < 8; r++) begin
				for (int c = 0; c < 8; c++) begin
					sum = 0;
					for (int k = 0; k < 8; k++) begin
						sum += longint'(samples[br*8+r][bc*8+k]) * idct_pkg::DCT_COEFF[k][c];
					end
					t[r][c] = sum >>> 8;
				end
			end
			for (int i = 0; i < 8; i++) begin
				for (int j = 0; j < 8; j++) begin
					sum = 0;
					for (int k = 0; k < 8; k++) begin
						sum += longint'(idct_pkg::DCT_COEFF[k][i]) * t[k][j];
					end
					sum = sum >>> 16;
					pix[j] = (sum < 0) ? 0 : (sum > 255) ? 255 : int'(sum);
				end
				for (int m = 0; m < 4; m++) begin
					addr = (br * 8 + i) * 16 + bc * 4 + m;
					expect_mem[addr] = frame_pkg::sram_data_t'(pix[2*m] * 256 + pix[2*m+1]);
				end
			end
		end
	end
endtask

task automatic pulse_start();
	@(negedge Clock);
	start_i = 1'b1;
	@(negedge Clock);
	start_i = 1'b0;
endtask

task automatic wait_done();
	int cycles;
	cycles = 0;
	while (done_o !== 1'b1) begin
		@(negedge Clock);
		cycles++;
		if (cycles > TIMEOUT) begin
			fail_run("timeout waiting for done_o");
		end
	end
	@(negedge Clock);
	compare_flag("done pulse width", 1'b0, done_o);
endtask

task automatic check_frame(input string name);
	for (int a = 0; a < MEM_WORDS; a++) begin
		compare_word($sformatf("%s word %0d", name, a), expect_mem[a], mem[a]);
	end
endtask

task automatic run_frame(input string name, input int mode);
	load_frame(mode);
	build_expected();
	pulse_start();
	wait_done();
	check_frame(name);
endtask

task automatic idle_after_reset();
	for (int i = 0; i < 20; i++) begin
		@(negedge Clock);
		compare_flag("reset_idle done_o", 1'b0, done_o);
		compare_flag("reset_idle sram_we_n_o", 1'b1, sram_we_n_o);
	end
endtask

task automatic saturation_frame();
	run_frame("saturation", 3);
	for (int r = 0; r < FRAME_ROWS; r++) begin
		for (int w = 0; w < 16; w++) begin
			compare_word("saturation level",
				(((r / 8 + w / 4) % 2) == 0) ? 16'hFFFF : 16'h0000, mem[r * 16 + w]);
		end
	end
endtask

// a start during the frame is ignored, then the frame ends with one done
task automatic restart_frame();
	run_frame("restart first", 2);
	load_frame(2);
	build_expected();
	pulse_start();
	repeat (700) begin
		@(negedge Clock);
		compare_flag("restart early done", 1'b0, done_o);
	end
	pulse_start();
	wait_done();
	check_frame("restart second");
	// no queued frame may follow
	repeat (3000) begin
		@(negedge Clock);
		compare_flag("restart extra done", 1'b0, done_o);
		compare_flag("restart extra write", 1'b1, sram_we_n_o);
	end
endtask

initial begin
	seed = 35;
	start_i = 1'b0;
	Resetn = 1'b0;
	for (int a = 0; a < MEM_WORDS; a++) begin
		mem[a] = '0;
	end
	repeat (4) @(negedge Clock);
	Resetn = 1'b1;
	idle_after_reset();
	run_frame("zero_samples", 0);
	run_frame("dc_blocks", 1);
	run_frame("random_samples", 2);
	saturation_frame();
	restart_frame();
	$display("Simulation PASSED");
	$finish;
end

// overall limit on run time
initial begin
	#(40 * 1000000);
	fail_run("simulation ran past its time limit");
end

endmodule

// ==== idct.f ====
src/frame_pkg.sv
src/idct_pkg.sv
src/block_buffer.sv
src/block_fetch.sv
src/matrix_engine.sv
src/block_writeback.sv
src/idct_sequencer.sv
src/idct_top.sv
verification/idct_chk.sv
verification/idct_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the IDCT testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wall -f idct.f --top-module idct_tb -o idct_sim

./obj_dir/idct_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "no pass line in sim.log"
	exit 1
fi
exit 0
